/* list.f */
+incdir+tb
common/tq_pkg.sv
design/tq_dct_4x4.sv
design/tq_blk_load.sv
design/tq_mem_arb.sv
design/tq_coef_mem.sv
tq_quant/tq_quant_scale.sv
tq_quant/tq_quant.sv
design/tq_top.sv
tb/tq_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tq_tb -Mdir obj_dir -o tq_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tq_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1

/* tb/tq_tb_model.svh */
`ifndef TQ_TB_MODEL_SVH
`define TQ_TB_MODEL_SVH

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Row k of the H.264 core transform matrix
function automatic int basis(input int k, input int i);
	case (k)
		0:       return 1;
		1:       return (i == 0) ? 2 : (i == 1) ? 1 : (i == 2) ? -1 : -2;
		2:       return (i == 0 || i == 3) ? 1 : -1;
		default: return (i == 0) ? 1 : (i == 1) ? -2 : (i == 2) ? 2 : -1;
	endcase
endfunction

function automatic int sample_at(input logic [4*ROW_W-1:0] blk, input int r, input int c);
	logic signed [RES_W-1:0] s;
	s = blk[r*ROW_W + c*RES_W +: RES_W];
	return int'(s);
endfunction

// Y = Cf * X * Cf', v is the vertical frequency and h the horizontal one
function automatic int coef_at(input logic [4*ROW_W-1:0] blk, input int v, input int h);
	int acc;
	acc = 0;
	for (int i = 0; i < 4; i++) begin
		for (int j = 0; j < 4; j++) begin
			acc += basis(v, i) * sample_at(blk, i, j) * basis(h, j);
		end
	end
	return acc;
endfunction

function automatic longint mf_at(input int rem, input int v, input int h);
	int tab_a [6];
	int tab_b [6];
	int tab_c [6];
	tab_a = '{13107, 11916, 10082, 9362, 8192, 7282};
	tab_b = '{5243, 4660, 4194, 3647, 3355, 2893};
	tab_c = '{8066, 7490, 6554, 5825, 5243, 4559};
	if (v % 2 == 0 && h % 2 == 0) begin
		return tab_a[rem];
	end else if (v % 2 == 1 && h % 2 == 1) begin
		return tab_b[rem];
	end
	return tab_c[rem];
endfunction

// Intra rounding, f = 2^qbits / 3
function automatic int level_at(input int w, input int qp, input int v, input int h);
	longint mag;
	longint f;
	int     qbits;
	qbits = 15 + qp / 6;
	f     = (longint'(1) << qbits) / 3;
	mag   = (w < 0) ? -w : w;
	mag   = (mag * mf_at(qp % 6, v, h) + f) >> qbits;
	return (w < 0) ? -int'(mag) : int'(mag);
endfunction

function automatic logic [4*LVL_W-1:0] level_row(input logic [4*ROW_W-1:0] blk,
	input int qp, input int v);
	logic [4*LVL_W-1:0] row;
	for (int h = 0; h < 4; h++) begin
		row[h*LVL_W +: LVL_W] = LVL_W'(level_at(coef_at(blk, v, h), qp, v, h));
	end
	return row;
endfunction

`endif

/* tb/tq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_tb import tq_pkg::*; ();

logic               clk_i;
logic               reset_i;
logic               row_vld_i;
logic [ROW_W-1:0]   row_i;
logic [QP_W-1:0]    qp_i;
logic               busy_o;
logic               lvl_vld_o;
logic [4*LVL_W-1:0] lvl_o;
logic [1:0]         lvl_row_o;
logic               lvl_last_o;

logic [4*LVL_W-1:0] exp_lvl [$];		// Expected rows in output order
logic [1:0]         exp_row [$];
logic [15:0]        lfsr_q;
int                 err_cnt;
int                 chk_cnt;
int                 test_cnt;
int                 blk_cnt;
int                 cycle_cnt;

`include "tq_tb_model.svh"

tq_top #(.NUM_BANKS(2)) dut_i (
	.clk_i      (clk_i),
	.reset_i    (reset_i),
	.row_vld_i  (row_vld_i),
	.row_i      (row_i),
	.qp_i       (qp_i),
	.busy_o     (busy_o),
	.lvl_vld_o  (lvl_vld_o),
	.lvl_o      (lvl_o),
	.lvl_row_o  (lvl_row_o),
	.lvl_last_o (lvl_last_o)
);

initial begin
	clk_i = 1'b0;
	forever #20 clk_i = ~clk_i;
end

always @(posedge clk_i) begin
	cycle_cnt <= cycle_cnt + 1;
	if (cycle_cnt > 400 * blk_cnt + 200) begin
		$display("Timeout after %0d cycles, %0d level rows never came out",
			cycle_cnt, exp_lvl.size());
		$display("TESTS FAILED");
		$finish;
	end
end

// ========================================
// Helpers
// ========================================
function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_step(lfsr_q);
		v = {v[14:0], lfsr_q[0]};
	end
	return v;
endfunction

function automatic logic [4*ROW_W-1:0] rand_block();
	logic [4*ROW_W-1:0] blk;
	logic [15:0]        bits;
	for (int i = 0; i < 16; i++) begin
		bits = rand_bits(RES_W);
		blk[i*RES_W +: RES_W] = bits[RES_W-1:0];
	end
	return blk;
endfunction

function automatic logic [4*ROW_W-1:0] checker_block(input bit invert);
	logic [4*ROW_W-1:0] blk;
	for (int i = 0; i < 16; i++) begin
		blk[i*RES_W +: RES_W] = ((((i / 4) + (i % 4)) % 2 == 0) ^ invert) ? 9'h0FF
			: 9'h100;			// +255 and -256
	end
	return blk;
endfunction

task automatic compare(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
	chk_cnt++;
	if (act_v !== exp_v) begin
		err_cnt++;
		$display("Fail at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
	end
endtask

task automatic check_output();
	logic [4*LVL_W-1:0] lvl_e;
	logic [1:0]         row_e;
	if (lvl_vld_o) begin
		if (exp_lvl.size() == 0) begin
			err_cnt++;
			$display("Error at %0t: level row %0d came out with no block pending",
				$time, lvl_row_o);
		end else begin
			lvl_e = exp_lvl.pop_front();
			row_e = exp_row.pop_front();
			compare("lvl_row_o", 64'(row_e), 64'(lvl_row_o));
			compare("lvl_o", 64'(lvl_e), 64'(lvl_o));
			compare("lvl_last_o", 64'(row_e == 2'd3), 64'(lvl_last_o));
		end
	end else if (lvl_last_o) begin
		err_cnt++;
		$display("Error at %0t: lvl_last_o high without lvl_vld_o", $time);
	end
endtask

// Outputs are stable at the falling edge, inputs change there too
task automatic tick();
	@(negedge clk_i);
	check_output();
endtask

task automatic expect_block(input logic [4*ROW_W-1:0] blk, input int qp);
	for (int v = 0; v < 4; v++) begin
		exp_lvl.push_back(level_row(blk, qp, v));
		exp_row.push_back(2'(v));
	end
endtask

task automatic drive_block(input logic [4*ROW_W-1:0] blk, input logic [QP_W-1:0] qp);
	blk_cnt++;
	tick();
	while (busy_o) begin
		tick();
	end
	for (int r = 0; r < 4; r++) begin
		row_vld_i = 1'b1;
		row_i     = blk[r*ROW_W +: ROW_W];
		qp_i      = qp;
		tick();
	end
	row_vld_i = 1'b0;
	compare("busy_o", 64'd1, 64'(busy_o));	// Rises with the fourth row
endtask

task automatic wait_drain();
	while (exp_lvl.size() != 0) begin
		tick();
	end
	repeat (4) tick();			// Catch stray rows
endtask

task automatic report_test(input string name, input int errs_before);
	test_cnt++;
	if (err_cnt == errs_before) begin
		$display("%s: ok", name);
	end else begin
		$display("%s: %0d errors", name, err_cnt - errs_before);
	end
endtask

// ========================================
// Tests
// ========================================
task automatic test_reset_idle();
	int e;
	e = err_cnt;
	for (int i = 0; i < 20; i++) begin
		tick();
		compare("busy_o", 64'd0, 64'(busy_o));
		compare("lvl_vld_o", 64'd0, 64'(lvl_vld_o));
		compare("lvl_last_o", 64'd0, 64'(lvl_last_o));
	end
	report_test("reset and idle", e);
endtask

task automatic test_dc_block();
	int                 e;
	int                 dc;
	logic [4*ROW_W-1:0] blk;
	e = err_cnt;
	for (int i = 0; i < 16; i++) begin
		blk[i*RES_W +: RES_W] = 9'd37;
	end
	dc = level_at(16 * 37, 28, 0, 0);	// Flat block has energy only at DC
	exp_lvl.push_back({{3*LVL_W{1'b0}}, LVL_W'(dc)});
	exp_row.push_back(2'd0);
	for (int v = 1; v < 4; v++) begin
		exp_lvl.push_back('0);
		exp_row.push_back(2'(v));
	end
	drive_block(blk, 6'd28);
	wait_drain();
	report_test("constant block at QP 28", e);
endtask

task automatic test_random_qp();
	int                 e;
	int                 qp_list [3];
	logic [4*ROW_W-1:0] blk;
	e = err_cnt;
	qp_list = '{0, 17, 51};
	for (int k = 0; k < 6; k++) begin
		blk = rand_block();
		expect_block(blk, qp_list[k % 3]);
		drive_block(blk, QP_W'(qp_list[k % 3]));
		wait_drain();
	end
	report_test("random blocks at QP 0, 17 and 51", e);
endtask

task automatic test_back_to_back();
	int                 e;
	int                 qp;
	logic [15:0]        bits;
	logic [4*ROW_W-1:0] blk;
	e = err_cnt;
	for (int k = 0; k < 8; k++) begin
		blk  = rand_block();
		bits = rand_bits(QP_W);
		qp   = int'(bits) % 52;
		expect_block(blk, qp);
		drive_block(blk, QP_W'(qp));	// Starts as soon as busy_o drops
	end
	wait_drain();
	report_test("back to back blocks", e);
endtask

task automatic test_extreme();
	int                 e;
	logic [4*ROW_W-1:0] blk;
	e = err_cnt;
	for (int k = 0; k < 4; k++) begin
		blk = checker_block(k[0]);
		expect_block(blk, k[1] ? 51 : 0);
		drive_block(blk, k[1] ? 6'd51 : 6'd0);
	end
	wait_drain();
	report_test("checkerboard of extreme residuals", e);
endtask

initial begin
	reset_i   = 1'b1;
	row_vld_i = 1'b0;
	row_i     = '0;
	qp_i      = '0;
	lfsr_q    = 16'd7;
	err_cnt   = 0;
	chk_cnt   = 0;
	test_cnt  = 0;
	blk_cnt   = 0;
	cycle_cnt = 0;
	repeat (4) @(negedge clk_i);
	reset_i = 1'b0;

	test_reset_idle();
	test_dc_block();
	test_random_qp();
	test_back_to_back();
	test_extreme();

	$display("Tests run: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
	if (err_cnt == 0) begin
		$display("TESTS PASSED");
	end else begin
		$display("TESTS FAILED");
	end
	$finish;
end

endmodule

`default_nettype wire

/* design/tq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_top import tq_pkg::*; #(
	parameter int NUM_BANKS = 2
) (
	input  logic               clk_i,
	input  logic               reset_i,
	input  logic               row_vld_i,
	input  logic [ROW_W-1:0]   row_i,
	input  logic [QP_W-1:0]    qp_i,
	output logic               busy_o,
	output logic               lvl_vld_o,
	output logic [4*LVL_W-1:0] lvl_o,
	output logic [1:0]         lvl_row_o,
	output logic               lvl_last_o
);

logic                 ld_req;
logic                 ld_gnt;
logic [ADDR_W-1:0]    ld_addr;
logic [MEM_W-1:0]     ld_wdata;
logic                 qn_req;
logic                 qn_gnt;
logic [ADDR_W-1:0]    qn_addr;
logic                 mem_we;
logic [ADDR_W-1:0]    mem_addr;
logic [MEM_W-1:0]     mem_wdata;
logic [MEM_W-1:0]     mem_rdata;
logic [NUM_BANKS-1:0] bank_full;

tq_blk_load #(.NUM_BANKS(NUM_BANKS)) u_load (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.row_vld_i   (row_vld_i),
	.row_i       (row_i),
	.qp_i        (qp_i),
	.ld_gnt_i    (ld_gnt),
	.bank_full_i (bank_full),
	.busy_o      (busy_o),
	.ld_req_o    (ld_req),
	.ld_addr_o   (ld_addr),
	.ld_wdata_o  (ld_wdata)
);

tq_mem_arb u_arb (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.ld_req_i    (ld_req),
	.ld_addr_i   (ld_addr),
	.ld_wdata_i  (ld_wdata),
	.qn_req_i    (qn_req),
	.qn_addr_i   (qn_addr),
	.ld_gnt_o    (ld_gnt),
	.qn_gnt_o    (qn_gnt),
	.mem_we_o    (mem_we),
	.mem_addr_o  (mem_addr),
	.mem_wdata_o (mem_wdata)
);

tq_coef_mem #(.NUM_BANKS(NUM_BANKS)) u_mem (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.we_i        (mem_we),
	.re_i        (qn_gnt),		// Quantizer grant is the read strobe
	.addr_i      (mem_addr),
	.wdata_i     (mem_wdata),
	.rdata_o     (mem_rdata),
	.bank_full_o (bank_full)
);

tq_quant #(.NUM_BANKS(NUM_BANKS)) u_quant (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.bank_full_i (bank_full),
	.qn_gnt_i    (qn_gnt),
	.mem_rdata_i (mem_rdata),
	.qn_req_o    (qn_req),
	.qn_addr_o   (qn_addr),
	.lvl_vld_o   (lvl_vld_o),
	.lvl_o       (lvl_o),
	.lvl_row_o   (lvl_row_o),
	.lvl_last_o  (lvl_last_o)
);

endmodule

`default_nettype wire

/* tq_quant/tq_quant.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_quant import tq_pkg::*; #(
	parameter int NUM_BANKS = 2
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic [NUM_BANKS-1:0] bank_full_i,
	input  logic                 qn_gnt_i,
	input  logic [MEM_W-1:0]     mem_rdata_i,
	output logic                 qn_req_o,
	output logic [ADDR_W-1:0]    qn_addr_o,
	output logic                 lvl_vld_o,
	output logic [4*LVL_W-1:0]   lvl_o,
	output logic [1:0]           lvl_row_o,
	output logic                 lvl_last_o
);

localparam int BANK_W = ADDR_W - 2;
localparam int ACC_W  = COEF_W + MF_W + 1;

logic [BANK_W-1:0]  bank_q;
logic [1:0]         row_q;
logic               rd_vld_q;		// Read data on mem_rdata_i
logic [1:0]         rd_row_q;
logic               lvl_vld_q;
logic               lvl_last_q;
logic [1:0]         lvl_row_q;
logic [4*LVL_W-1:0] lvl_q;
logic [4*MF_W-1:0]  mf;
logic [QB_W-1:0]    qbits;
logic [F_W-1:0]     f;
logic [COEF_W-1:0]  coef [4];
logic [COEF_W-1:0]  mag  [4];
logic [ACC_W-1:0]   acc  [4];
logic [ACC_W-1:0]   sh   [4];
logic [4*LVL_W-1:0] lvl_d;

assign qn_req_o  = bank_full_i[bank_q];
assign qn_addr_o = {bank_q, row_q};

tq_quant_scale u_scale (
	.qp_i    (mem_rdata_i[MEM_W-1 -: QP_W]),
	.row_i   (rd_row_q),
	.mf_o    (mf),
	.qbits_o (qbits),
	.f_o     (f)
);

// ========================================
// Level = sign * ((|W| * MF + f) >> qbits)
// ========================================
always_comb begin
	for (int c = 0; c < 4; c++) begin
		coef[c] = mem_rdata_i[c*COEF_W +: COEF_W];
		mag[c]  = coef[c][COEF_W-1] ? (~coef[c] + 1'b1) : coef[c];
		acc[c]  = mag[c] * mf[c*MF_W +: MF_W] + f;
		sh[c]   = acc[c] >> qbits;
		lvl_d[c*LVL_W +: LVL_W] = coef[c][COEF_W-1] ? (~sh[c][LVL_W-1:0] + 1'b1)
			: sh[c][LVL_W-1:0];
	end
end

always_ff @(posedge clk_i) begin
	if (qn_gnt_i) begin
		rd_row_q <= row_q;
	end
	if (rd_vld_q) begin
		lvl_q     <= lvl_d;
		lvl_row_q <= rd_row_q;
	end
end

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		bank_q     <= '0;
		row_q      <= '0;
		rd_vld_q   <= 1'b0;
		lvl_vld_q  <= 1'b0;
		lvl_last_q <= 1'b0;
	end else begin
		rd_vld_q   <= qn_gnt_i;
		lvl_vld_q  <= rd_vld_q;
		lvl_last_q <= rd_vld_q & (rd_row_q == 2'd3);
		if (qn_gnt_i) begin
			row_q <= row_q + 2'd1;
			if (row_q == 2'd3) begin
				bank_q <= (bank_q == BANK_W'(NUM_BANKS - 1)) ? '0 : bank_q + 1'b1;
			end
		end
	end
end

assign lvl_vld_o  = lvl_vld_q;
assign lvl_o      = lvl_q;
assign lvl_row_o  = lvl_row_q;
assign lvl_last_o = lvl_last_q;

endmodule

`default_nettype wire

/* tq_quant/tq_quant_scale.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_quant_scale import tq_pkg::*; (
	input  logic [QP_W-1:0]   qp_i,
	input  logic [1:0]        row_i,
	output logic [4*MF_W-1:0] mf_o,
	output logic [QB_W-1:0]   qbits_o,
	output logic [F_W-1:0]    f_o
);

logic [QP_W-1:0] qp_lim;
logic [3:0]      qp_div;
logic [QP_W-1:0] qp_six;
logic [2:0]      qp_rem;
logic [1:0]      cls [4];
logic [23:0]     f_pat;

// ========================================
// QP split into qp/6 and qp%6
// ========================================
always_comb begin
	qp_lim = (qp_i > QP_W'(QP_MAX)) ? QP_W'(QP_MAX) : qp_i;
	if      (qp_lim >= 6'd48) qp_div = 4'd8;
	else if (qp_lim >= 6'd42) qp_div = 4'd7;
	else if (qp_lim >= 6'd36) qp_div = 4'd6;
	else if (qp_lim >= 6'd30) qp_div = 4'd5;
	else if (qp_lim >= 6'd24) qp_div = 4'd4;
	else if (qp_lim >= 6'd18) qp_div = 4'd3;
	else if (qp_lim >= 6'd12) qp_div = 4'd2;
	else if (qp_lim >= 6'd6)  qp_div = 4'd1;
	else                      qp_div = 4'd0;
	qp_six = {qp_div, 2'b00} + {1'b0, qp_div, 1'b0};	// 4q + 2q
	qp_rem = 3'(qp_lim - qp_six);
end

assign qbits_o = 5'd15 + {1'b0, qp_div};

// Floor of 2^qbits / 3 is an alternating bit pattern
assign f_pat = 24'h555555 >> (5'd24 - qbits_o);
assign f_o   = f_pat[F_W-1:0];

for (genvar c = 0; c < 4; c++) begin : g_col
	localparam bit COL_ODD = (c % 2) == 1;
	assign cls[c] = (row_i[0] != COL_ODD) ? CLS_C : (COL_ODD ? CLS_B : CLS_A);
	assign mf_o[c*MF_W +: MF_W] = quant_mf(qp_rem, cls[c]);
end

endmodule

`default_nettype wire

/* design/tq_coef_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_coef_mem import tq_pkg::*; #(
	parameter int NUM_BANKS = 2
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 we_i,
	input  logic                 re_i,
	input  logic [ADDR_W-1:0]    addr_i,
	input  logic [MEM_W-1:0]     wdata_i,
	output logic [MEM_W-1:0]     rdata_o,
	output logic [NUM_BANKS-1:0] bank_full_o
);

localparam int DEPTH  = NUM_BANKS * 4;
localparam int BANK_W = ADDR_W - 2;

logic [MEM_W-1:0]     mem_q [DEPTH];
logic [MEM_W-1:0]     rdata_q;
logic [NUM_BANKS-1:0] full_q;
logic [BANK_W-1:0]    bank;
logic                 row_last;

assign bank     = addr_i[ADDR_W-1:2];
assign row_last = (addr_i[1:0] == 2'd3);

always_ff @(posedge clk_i) begin
	if (we_i) begin
		mem_q[addr_i] <= wdata_i;
	end
	if (re_i) begin
		rdata_q <= mem_q[addr_i];	// One cycle read
	end
end

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		full_q <= '0;
	end else begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (we_i && row_last && bank == BANK_W'(b)) begin
				full_q[b] <= 1'b1;
			end else if (re_i && row_last && bank == BANK_W'(b)) begin
				full_q[b] <= 1'b0;
			end
		end
	end
end

assign rdata_o     = rdata_q;
assign bank_full_o = full_q;

endmodule

`default_nettype wire

/* design/tq_mem_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_mem_arb import tq_pkg::*; (
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              ld_req_i,
	input  logic [ADDR_W-1:0] ld_addr_i,
	input  logic [MEM_W-1:0]  ld_wdata_i,
	input  logic              qn_req_i,
	input  logic [ADDR_W-1:0] qn_addr_i,
	output logic              ld_gnt_o,
	output logic              qn_gnt_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output logic [MEM_W-1:0]  mem_wdata_o
);

logic last_ld_q;				// Loader won the last grant

// On a conflict the side that lost last time wins
assign ld_gnt_o = ld_req_i & (~qn_req_i | ~last_ld_q);
assign qn_gnt_o = qn_req_i & ~ld_gnt_o;

assign mem_we_o    = ld_gnt_o;		// Loader only writes
assign mem_addr_o  = ld_gnt_o ? ld_addr_i : qn_addr_i;
assign mem_wdata_o = ld_wdata_i;

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		last_ld_q <= 1'b0;
	end else if (ld_gnt_o) begin
		last_ld_q <= 1'b1;
	end else if (qn_gnt_o) begin
		last_ld_q <= 1'b0;
	end
end

endmodule

`default_nettype wire

/* design/tq_blk_load.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_blk_load import tq_pkg::*; #(
	parameter int NUM_BANKS = 2
) (
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 row_vld_i,
	input  logic [ROW_W-1:0]     row_i,
	input  logic [QP_W-1:0]      qp_i,
	input  logic                 ld_gnt_i,
	input  logic [NUM_BANKS-1:0] bank_full_i,
	output logic                 busy_o,
	output logic                 ld_req_o,
	output logic [ADDR_W-1:0]    ld_addr_o,
	output logic [MEM_W-1:0]     ld_wdata_o
);

localparam int BANK_W = ADDR_W - 2;

logic signed [RES_W-1:0]  samp_q [4][4];
logic signed [COEF_W-1:0] dct_d  [4][4];	// Column major, [freq_h][freq_v]
logic [CROW_W-1:0]        coef_q [4];
logic [QP_W-1:0]          qp_q;
logic [1:0]               cnt_q;
logic                     cap_q;		// Block complete, capture next edge
logic                     wr_act_q;
logic [1:0]               wr_row_q;
logic [BANK_W-1:0]        bank_q;
logic                     busy_q;
logic                     row_take;
logic                     row_last;

assign row_take = row_vld_i & ~busy_q;
assign row_last = row_take & (cnt_q == 2'd3);

tq_dct_4x4 u_dct (
	.dct_s00_i(samp_q[0][0]), .dct_s01_i(samp_q[0][1]), .dct_s02_i(samp_q[0][2]), .dct_s03_i(samp_q[0][3]),
	.dct_s10_i(samp_q[1][0]), .dct_s11_i(samp_q[1][1]), .dct_s12_i(samp_q[1][2]), .dct_s13_i(samp_q[1][3]),
	.dct_s20_i(samp_q[2][0]), .dct_s21_i(samp_q[2][1]), .dct_s22_i(samp_q[2][2]), .dct_s23_i(samp_q[2][3]),
	.dct_s30_i(samp_q[3][0]), .dct_s31_i(samp_q[3][1]), .dct_s32_i(samp_q[3][2]), .dct_s33_i(samp_q[3][3]),
	.dct_d00_o(dct_d[0][0]), .dct_d01_o(dct_d[0][1]), .dct_d02_o(dct_d[0][2]), .dct_d03_o(dct_d[0][3]),
	.dct_d10_o(dct_d[1][0]), .dct_d11_o(dct_d[1][1]), .dct_d12_o(dct_d[1][2]), .dct_d13_o(dct_d[1][3]),
	.dct_d20_o(dct_d[2][0]), .dct_d21_o(dct_d[2][1]), .dct_d22_o(dct_d[2][2]), .dct_d23_o(dct_d[2][3]),
	.dct_d30_o(dct_d[3][0]), .dct_d31_o(dct_d[3][1]), .dct_d32_o(dct_d[3][2]), .dct_d33_o(dct_d[3][3])
);

always_ff @(posedge clk_i) begin
	if (row_take) begin
		for (int r = 0; r < 3; r++) begin
			samp_q[r] <= samp_q[r+1];	// Oldest row ends up in row 0
		end
		for (int c = 0; c < 4; c++) begin
			samp_q[3][c] <= row_i[c*RES_W +: RES_W];
		end
		if (cnt_q == 2'd0) begin
			qp_q <= qp_i;
		end
	end
	if (cap_q) begin
		for (int r = 0; r < 4; r++) begin
			coef_q[r] <= {dct_d[3][r], dct_d[2][r], dct_d[1][r], dct_d[0][r]};
		end
	end
end

always_ff @(posedge clk_i) begin
	if (reset_i) begin
		cnt_q    <= '0;
		cap_q    <= 1'b0;
		wr_act_q <= 1'b0;
		wr_row_q <= '0;
		bank_q   <= '0;
		busy_q   <= 1'b0;
	end else begin
		cap_q <= row_last;
		if (row_take) begin
			cnt_q <= cnt_q + 2'd1;
		end
		if (cap_q) begin
			wr_act_q <= 1'b1;
		end
		if (ld_gnt_i) begin
			wr_row_q <= wr_row_q + 2'd1;
			if (wr_row_q == 2'd3) begin
				wr_act_q <= 1'b0;
				bank_q   <= (bank_q == BANK_W'(NUM_BANKS - 1)) ? '0 : bank_q + 1'b1;
			end
		end
		if (row_last) begin
			busy_q <= 1'b1;
		end else if (~cap_q & ~wr_act_q & ~bank_full_i[bank_q]) begin
			busy_q <= 1'b0;			// Wait for the next bank to drain
		end
	end
end

assign busy_o     = busy_q;
assign ld_req_o   = wr_act_q;
assign ld_addr_o  = {bank_q, wr_row_q};
assign ld_wdata_o = {qp_q, coef_q[wr_row_q]};

endmodule

`default_nettype wire

/* design/tq_dct_4x4.sv */
`timescale 1ns/1ps
`default_nettype none

module tq_dct_4x4 import tq_pkg::*; (
	input  logic signed [RES_W-1:0]  dct_s00_i, dct_s01_i, dct_s02_i, dct_s03_i,
	input  logic signed [RES_W-1:0]  dct_s10_i, dct_s11_i, dct_s12_i, dct_s13_i,
	input  logic signed [RES_W-1:0]  dct_s20_i, dct_s21_i, dct_s22_i, dct_s23_i,
	input  logic signed [RES_W-1:0]  dct_s30_i, dct_s31_i, dct_s32_i, dct_s33_i,
	output logic signed [COEF_W-1:0] dct_d00_o, dct_d01_o, dct_d02_o, dct_d03_o,
	output logic signed [COEF_W-1:0] dct_d10_o, dct_d11_o, dct_d12_o, dct_d13_o,
	output logic signed [COEF_W-1:0] dct_d20_o, dct_d21_o, dct_d22_o, dct_d23_o,
	output logic signed [COEF_W-1:0] dct_d30_o, dct_d31_o, dct_d32_o, dct_d33_o
);

localparam int MID_W = RES_W + 3;

// Horizontal pass result, first index is the sample row
logic signed [MID_W-1:0] h00, h01, h02, h03;
logic signed [MID_W-1:0] h10, h11, h12, h13;
logic signed [MID_W-1:0] h20, h21, h22, h23;
logic signed [MID_W-1:0] h30, h31, h32, h33;

// ========================================
// Row transforms
// ========================================
tq_dct4 #(.IN_W(RES_W)) u_row0 (
	.s0_i(dct_s00_i), .s1_i(dct_s01_i), .s2_i(dct_s02_i), .s3_i(dct_s03_i),
	.d0_o(h00), .d1_o(h01), .d2_o(h02), .d3_o(h03)
);
tq_dct4 #(.IN_W(RES_W)) u_row1 (
	.s0_i(dct_s10_i), .s1_i(dct_s11_i), .s2_i(dct_s12_i), .s3_i(dct_s13_i),
	.d0_o(h10), .d1_o(h11), .d2_o(h12), .d3_o(h13)
);
tq_dct4 #(.IN_W(RES_W)) u_row2 (
	.s0_i(dct_s20_i), .s1_i(dct_s21_i), .s2_i(dct_s22_i), .s3_i(dct_s23_i),
	.d0_o(h20), .d1_o(h21), .d2_o(h22), .d3_o(h23)
);
tq_dct4 #(.IN_W(RES_W)) u_row3 (
	.s0_i(dct_s30_i), .s1_i(dct_s31_i), .s2_i(dct_s32_i), .s3_i(dct_s33_i),
	.d0_o(h30), .d1_o(h31), .d2_o(h32), .d3_o(h33)
);

// ========================================
// Column transforms, output dct_dKJ is
// horizontal freq K, vertical freq J
// ========================================
tq_dct4 #(.IN_W(MID_W)) u_col0 (
	.s0_i(h00), .s1_i(h10), .s2_i(h20), .s3_i(h30),
	.d0_o(dct_d00_o), .d1_o(dct_d01_o), .d2_o(dct_d02_o), .d3_o(dct_d03_o)
);
tq_dct4 #(.IN_W(MID_W)) u_col1 (
	.s0_i(h01), .s1_i(h11), .s2_i(h21), .s3_i(h31),
	.d0_o(dct_d10_o), .d1_o(dct_d11_o), .d2_o(dct_d12_o), .d3_o(dct_d13_o)
);
tq_dct4 #(.IN_W(MID_W)) u_col2 (
	.s0_i(h02), .s1_i(h12), .s2_i(h22), .s3_i(h32),
	.d0_o(dct_d20_o), .d1_o(dct_d21_o), .d2_o(dct_d22_o), .d3_o(dct_d23_o)
);
tq_dct4 #(.IN_W(MID_W)) u_col3 (
	.s0_i(h03), .s1_i(h13), .s2_i(h23), .s3_i(h33),
	.d0_o(dct_d30_o), .d1_o(dct_d31_o), .d2_o(dct_d32_o), .d3_o(dct_d33_o)
);

endmodule

module tq_dct4 #(
	parameter int IN_W = 9
) (
	input  logic signed [IN_W-1:0] s0_i, s1_i, s2_i, s3_i,
	output logic signed [IN_W+2:0] d0_o, d1_o, d2_o, d3_o
);

logic signed [IN_W+2:0] sum03, sum12, dif12, dif03;

assign sum03 = s0_i + s3_i;		// Operands sign extend to the full width
assign sum12 = s1_i + s2_i;
assign dif12 = s1_i - s2_i;
assign dif03 = s0_i - s3_i;

assign d0_o = sum03 + sum12;
assign d1_o = (dif03 <<< 1) + dif12;
assign d2_o = sum03 - sum12;
assign d3_o = dif03 - (dif12 <<< 1);

endmodule

`default_nettype wire

/* common/tq_pkg.sv */
`default_nettype none

package tq_pkg;

	localparam int RES_W  = 9;		// Residual sample, signed
	localparam int COEF_W = 15;		// Coefficient after 2-D transform
	localparam int LVL_W  = 15;		// Quantized level
	localparam int QP_W   = 6;
	localparam int QP_MAX = 51;
	localparam int ROW_W  = 4 * RES_W;
	localparam int CROW_W = 4 * COEF_W;
	localparam int MEM_W  = CROW_W + QP_W;	// QP in the top bits
	localparam int ADDR_W = 3;		// Bank bit and two row bits
	localparam int MF_W   = 14;
	localparam int QB_W   = 5;
	localparam int F_W    = 22;

	localparam logic [1:0] CLS_A = 2'd0;	// Row and column even
	localparam logic [1:0] CLS_B = 2'd1;	// Row and column odd
	localparam logic [1:0] CLS_C = 2'd2;

	localparam logic [MF_W-1:0] MF_A [6] = '{14'd13107, 14'd11916, 14'd10082,
		14'd9362, 14'd8192, 14'd7282};
	localparam logic [MF_W-1:0] MF_B [6] = '{14'd5243, 14'd4660, 14'd4194,
		14'd3647, 14'd3355, 14'd2893};
	localparam logic [MF_W-1:0] MF_C [6] = '{14'd8066, 14'd7490, 14'd6554,
		14'd5825, 14'd5243, 14'd4559};

	function automatic logic [MF_W-1:0] quant_mf(input logic [2:0] rem, input logic [1:0] cls);
		logic [2:0] idx;
		idx = (rem > 3'd5) ? 3'd5 : rem;
		case (cls)
			CLS_A:   return MF_A[idx];
			CLS_B:   return MF_B[idx];
			default: return MF_C[idx];
		endcase
	endfunction

endpackage

`default_nettype wire
